// File: logic/cddip_support_params.svh
// Width, block ID, register offset and interrupt count macros for the support block.
`ifndef CDDIP_SUPPORT_PARAMS_SVH
`define CDDIP_SUPPORT_PARAMS_SVH

`define RBUS_ADDR_BITS 16
`define RBUS_DATA_BITS 32
`define LOCL_ADDR_BITS 8

`define CDDIP_BLKID 16'h0cd1
`define CDDIP_REVID 16'h0002

`define CTL_BITS 8

`define INT_BITS 14
`define INT_ADDR_BITS 2

// local register offsets, byte addressed in steps of four.
`define REG_OFF_BLKID_REVID  8'h00
`define REG_OFF_SOFT_RST     8'h04
`define REG_OFF_CTL          8'h08
`define REG_OFF_IM_AVAILABLE 8'h0c
`define REG_OFF_IM_CONSUMED  8'h10
`define REG_OFF_INT_STATUS   8'h14
`define REG_OFF_INT_MASK     8'h18

// sub-addresses inside the interrupt window.
`define INT_ADDR_STATUS 2'd0
`define INT_ADDR_MASK   2'd1

`endif

// File: logic/cddip_support_pkg.sv
// Ring, local bus, bank handshake, control, interrupt types and the register offset enum.
`include "cddip_support_params.svh"

package cddip_support_pkg;

  typedef struct packed {
    logic [`RBUS_ADDR_BITS-1:0] addr;
    logic                       wr_strb;
    logic [`RBUS_DATA_BITS-1:0] wr_data;
    logic                       rd_strb;
    logic [`RBUS_DATA_BITS-1:0] rd_data;
    logic                       ack;
    logic                       err_ack;
  } rbus_ring_t;

  typedef struct packed {
    logic [`LOCL_ADDR_BITS-1:0] addr;    // offset from the window start.
    logic                       wr_strb;
    logic                       rd_strb;
    logic [`RBUS_DATA_BITS-1:0] wr_data;
  } locl_req_t;

  typedef struct packed {
    logic [`RBUS_DATA_BITS-1:0] rd_data;
    logic                       ack;
    logic                       err_ack;
  } locl_rsp_t;

  typedef struct packed {
    logic bank_hi;
    logic bank_lo;  // bit 0.
  } im_bank_t;

  typedef struct packed {
    logic [`CTL_BITS-2:0] spare_ctl;
    logic                 engine_enable;
  } ctl_t;

  // last field is bit 0.
  typedef struct packed {
    logic xp10_tlvp;
    logic xp10_uncor_ecc;
    logic su_uncor_ecc;
    logic cg_tlvp;
    logic crcc_tlvp;
    logic crcg_tlvp;
    logic prefix_tlvp;
    logic osf_tlvp;
    logic osf_uncor_ecc;
    logic isf_sys_stall;
    logic isf_ovfl;
    logic isf_prot_err;
    logic isf_tlvp;
    logic isf_uncor_ecc;
  } int_src_t;

  typedef struct packed {
    logic [`INT_ADDR_BITS-1:0] addr;
    logic                      rd;
    logic                      wr;
    logic [`INT_BITS-1:0]      data;
  } int_req_t;

  typedef enum logic [`LOCL_ADDR_BITS-1:0] {
    REG_BLKID_REVID  = `REG_OFF_BLKID_REVID,
    REG_SOFT_RST     = `REG_OFF_SOFT_RST,
    REG_CTL          = `REG_OFF_CTL,
    REG_IM_AVAILABLE = `REG_OFF_IM_AVAILABLE,
    REG_IM_CONSUMED  = `REG_OFF_IM_CONSUMED,
    REG_INT_STATUS   = `REG_OFF_INT_STATUS,
    REG_INT_MASK     = `REG_OFF_INT_MASK
  } reg_offset_e;

endpackage

// File: logic/rbus_ring_node.sv
// Register bus ring node with window claim, local request generation and response merge.
`timescale 1ns/1ps
`include "cddip_support_params.svh"

module rbus_ring_node (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [`RBUS_ADDR_BITS-1:0]    i_cfg_start_addr,
  input  logic [`RBUS_ADDR_BITS-1:0]    i_cfg_end_addr,
  input  cddip_support_pkg::rbus_ring_t i_rbus_ring,
  input  cddip_support_pkg::locl_rsp_t  i_locl_rsp,
  output cddip_support_pkg::rbus_ring_t o_rbus_ring,
  output cddip_support_pkg::locl_req_t  o_locl_req
);

  logic                          in_window;
  logic                          claim_wr;
  logic                          claim_rd;
  logic                          locl_done;
  logic [`RBUS_ADDR_BITS-1:0]    offset;
  cddip_support_pkg::rbus_ring_t ring_q;
  logic                          req_wr_q;
  logic                          req_rd_q;
  logic [`LOCL_ADDR_BITS-1:0]    req_addr_q;
  logic [`RBUS_DATA_BITS-1:0]    req_data_q;

  assign in_window = (i_rbus_ring.addr >= i_cfg_start_addr) &&
                     (i_rbus_ring.addr <= i_cfg_end_addr);
  assign claim_wr  = i_rbus_ring.wr_strb & in_window;
  assign claim_rd  = i_rbus_ring.rd_strb & in_window;
  assign offset    = i_rbus_ring.addr - i_cfg_start_addr;  // window spans at most 256 bytes.
  assign locl_done = i_locl_rsp.ack | i_locl_rsp.err_ack;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ring_q   <= '0;
      req_wr_q <= 1'b0;
      req_rd_q <= 1'b0;
    end else begin
      ring_q.addr    <= i_rbus_ring.addr;
      ring_q.wr_data <= i_rbus_ring.wr_data;
      ring_q.wr_strb <= i_rbus_ring.wr_strb & ~in_window;  // claimed strobes stop here.
      ring_q.rd_strb <= i_rbus_ring.rd_strb & ~in_window;
      if (locl_done) begin
        ring_q.rd_data <= i_locl_rsp.rd_data;
        ring_q.ack     <= i_locl_rsp.ack;
        ring_q.err_ack <= i_locl_rsp.err_ack;
      end else begin
        ring_q.rd_data <= i_rbus_ring.rd_data;
        ring_q.ack     <= i_rbus_ring.ack;
        ring_q.err_ack <= i_rbus_ring.err_ack;
      end
      req_wr_q <= claim_wr;
      req_rd_q <= claim_rd;
    end
  end

  always_ff @(posedge clk) begin
    if (claim_wr | claim_rd) begin
      req_addr_q <= offset[`LOCL_ADDR_BITS-1:0];
      req_data_q <= i_rbus_ring.wr_data;
    end
  end

  assign o_rbus_ring = ring_q;
  assign o_locl_req  = '{addr:    req_addr_q,
                         wr_strb: req_wr_q,
                         rd_strb: req_rd_q,
                         wr_data: req_data_q};

endmodule

// File: logic/support_regs.sv
// Local register file with bank handshake and interrupt window decode.
`timescale 1ns/1ps
`include "cddip_support_params.svh"

module support_regs (
  input  logic                         clk,
  input  logic                         rst_n,
  input  cddip_support_pkg::locl_req_t i_locl_req,
  input  cddip_support_pkg::im_bank_t  i_im_available_htf_bl,
  input  cddip_support_pkg::im_bank_t  i_im_available_lz77d,
  input  cddip_support_pkg::im_bank_t  i_im_available_xpd,
  input  logic [`INT_BITS-1:0]         i_int_rd_data,
  output cddip_support_pkg::locl_rsp_t o_locl_rsp,
  output cddip_support_pkg::im_bank_t  o_im_consumed_htf_bl,
  output cddip_support_pkg::im_bank_t  o_im_consumed_lz77d,
  output cddip_support_pkg::im_bank_t  o_im_consumed_xpd,
  output cddip_support_pkg::ctl_t      o_ctl,
  output logic                         o_soft_rst,
  output cddip_support_pkg::int_req_t  o_int_req
);

  cddip_support_pkg::reg_offset_e offset;
  logic                           access;
  logic                           known;
  logic                           int_hit;
  logic [`INT_ADDR_BITS-1:0]      int_addr;
  logic [`RBUS_DATA_BITS-1:0]     rd_mux;
  logic                           consumed_wr;
  logic [5:0]                     consumed_bits;
  cddip_support_pkg::im_bank_t    avail_htf_bl_q;
  cddip_support_pkg::im_bank_t    avail_lz77d_q;
  cddip_support_pkg::im_bank_t    avail_xpd_q;
  cddip_support_pkg::ctl_t        ctl_q;
  logic                           soft_rst_q;
  logic                           ack_q;
  logic                           err_ack_q;
  logic [`RBUS_DATA_BITS-1:0]     rd_data_q;

  assign offset = cddip_support_pkg::reg_offset_e'(i_locl_req.addr);
  assign access = i_locl_req.wr_strb | i_locl_req.rd_strb;

  always_comb begin
    known    = 1'b1;
    int_hit  = 1'b0;
    int_addr = `INT_ADDR_STATUS;
    rd_mux   = '0;
    case (offset)
      cddip_support_pkg::REG_BLKID_REVID:  rd_mux = {`CDDIP_BLKID, `CDDIP_REVID};
      cddip_support_pkg::REG_SOFT_RST:     rd_mux = `RBUS_DATA_BITS'(soft_rst_q);
      cddip_support_pkg::REG_CTL:          rd_mux = `RBUS_DATA_BITS'(ctl_q);
      cddip_support_pkg::REG_IM_AVAILABLE: begin
        rd_mux = `RBUS_DATA_BITS'({avail_xpd_q, avail_lz77d_q, avail_htf_bl_q});
      end
      cddip_support_pkg::REG_IM_CONSUMED:  rd_mux = '0;  // write-only.
      cddip_support_pkg::REG_INT_STATUS: begin
        int_hit = 1'b1;
        rd_mux  = `RBUS_DATA_BITS'(i_int_rd_data);
      end
      cddip_support_pkg::REG_INT_MASK: begin
        int_hit  = 1'b1;
        int_addr = `INT_ADDR_MASK;
        rd_mux   = `RBUS_DATA_BITS'(i_int_rd_data);
      end
      default: known = 1'b0;
    endcase
  end

  assign consumed_wr   = i_locl_req.wr_strb && (offset == cddip_support_pkg::REG_IM_CONSUMED);
  assign consumed_bits = consumed_wr ? i_locl_req.wr_data[5:0] : 6'd0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      avail_htf_bl_q       <= '0;
      avail_lz77d_q        <= '0;
      avail_xpd_q          <= '0;
      o_im_consumed_htf_bl <= '0;
      o_im_consumed_lz77d  <= '0;
      o_im_consumed_xpd    <= '0;
      ctl_q                <= '0;
      soft_rst_q           <= 1'b0;
      ack_q                <= 1'b0;
      err_ack_q            <= 1'b0;
    end else begin
      avail_htf_bl_q       <= i_im_available_htf_bl;
      avail_lz77d_q        <= i_im_available_lz77d;
      avail_xpd_q          <= i_im_available_xpd;
      o_im_consumed_htf_bl <= consumed_bits[1:0];  // one-cycle pulses.
      o_im_consumed_lz77d  <= consumed_bits[3:2];
      o_im_consumed_xpd    <= consumed_bits[5:4];
      ack_q                <= access & known;
      err_ack_q            <= access & ~known;
      if (i_locl_req.wr_strb) begin
        case (offset)
          cddip_support_pkg::REG_SOFT_RST: soft_rst_q <= i_locl_req.wr_data[0];
          cddip_support_pkg::REG_CTL: begin
            ctl_q <= cddip_support_pkg::ctl_t'(i_locl_req.wr_data[`CTL_BITS-1:0]);
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    rd_data_q <= i_locl_req.rd_strb ? rd_mux : '0;
  end

  assign o_int_req  = '{addr: int_addr,
                        rd:   i_locl_req.rd_strb & int_hit,
                        wr:   i_locl_req.wr_strb & int_hit,
                        data: i_locl_req.wr_data[`INT_BITS-1:0]};
  assign o_locl_rsp = '{rd_data: rd_data_q, ack: ack_q, err_ack: err_ack_q};
  assign o_ctl      = ctl_q;
  assign o_soft_rst = soft_rst_q;

endmodule

// File: logic/event_interrupt.sv
// Event interrupt controller with sticky status, mask and registered interrupt output.
`timescale 1ns/1ps
`include "cddip_support_params.svh"

module event_interrupt #(
  parameter int N_INT_BITS = `INT_BITS
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  cddip_support_pkg::int_src_t i_int_src,
  input  cddip_support_pkg::int_req_t i_int_req,
  output logic [N_INT_BITS-1:0]       o_int_rd_data,
  output logic                        o_int
);

  logic [N_INT_BITS-1:0] src_vec;
  logic [N_INT_BITS-1:0] wr_vec;
  logic [N_INT_BITS-1:0] clr_vec;
  logic [N_INT_BITS-1:0] status_q;
  logic [N_INT_BITS-1:0] mask_q;
  logic                  status_wr;
  logic                  mask_wr;

  assign src_vec   = N_INT_BITS'(i_int_src);
  assign wr_vec    = N_INT_BITS'(i_int_req.data);
  assign status_wr = i_int_req.wr && (i_int_req.addr == `INT_ADDR_STATUS);
  assign mask_wr   = i_int_req.wr && (i_int_req.addr == `INT_ADDR_MASK);
  assign clr_vec   = status_wr ? wr_vec : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status_q <= '0;
      mask_q   <= '1;  // every source starts masked.
      o_int    <= 1'b0;
    end else begin
      status_q <= (status_q & ~clr_vec) | src_vec;  // a new strobe beats the clear.
      if (mask_wr) begin
        mask_q <= wr_vec;
      end
      o_int <= |(status_q & ~mask_q);
    end
  end

  always_comb begin
    o_int_rd_data = '0;
    if (i_int_req.rd) begin
      case (i_int_req.addr)
        `INT_ADDR_STATUS: o_int_rd_data = status_q;
        `INT_ADDR_MASK:   o_int_rd_data = mask_q;
        default:          o_int_rd_data = '0;
      endcase
    end
  end

endmodule

// File: logic/cddip_support_top.sv
// Support block top level joining the ring node, register file and interrupt controller.
`timescale 1ns/1ps
`include "cddip_support_params.svh"

module cddip_support_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [`RBUS_ADDR_BITS-1:0]    i_cfg_start_addr,
  input  logic [`RBUS_ADDR_BITS-1:0]    i_cfg_end_addr,
  input  cddip_support_pkg::rbus_ring_t i_rbus_ring,
  output cddip_support_pkg::rbus_ring_t o_rbus_ring,
  input  cddip_support_pkg::im_bank_t   i_im_available_htf_bl,
  input  cddip_support_pkg::im_bank_t   i_im_available_lz77d,
  input  cddip_support_pkg::im_bank_t   i_im_available_xpd,
  output cddip_support_pkg::im_bank_t   o_im_consumed_htf_bl,
  output cddip_support_pkg::im_bank_t   o_im_consumed_lz77d,
  output cddip_support_pkg::im_bank_t   o_im_consumed_xpd,
  input  cddip_support_pkg::int_src_t   i_int_src,
  output logic                          o_int,
  output cddip_support_pkg::ctl_t       o_ctl,
  output logic                          o_soft_rst
);

  cddip_support_pkg::locl_req_t locl_req;
  cddip_support_pkg::locl_rsp_t locl_rsp;
  cddip_support_pkg::int_req_t  int_req;
  logic [`INT_BITS-1:0]         int_rd_data;

  rbus_ring_node u_ring (
    .clk              (clk),
    .rst_n            (rst_n),
    .i_cfg_start_addr (i_cfg_start_addr),
    .i_cfg_end_addr   (i_cfg_end_addr),
    .i_rbus_ring      (i_rbus_ring),
    .i_locl_rsp       (locl_rsp),
    .o_rbus_ring      (o_rbus_ring),
    .o_locl_req       (locl_req)
  );

  support_regs u_regs (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .i_locl_req            (locl_req),
    .i_im_available_htf_bl (i_im_available_htf_bl),
    .i_im_available_lz77d  (i_im_available_lz77d),
    .i_im_available_xpd    (i_im_available_xpd),
    .i_int_rd_data         (int_rd_data),
    .o_locl_rsp            (locl_rsp),
    .o_im_consumed_htf_bl  (o_im_consumed_htf_bl),
    .o_im_consumed_lz77d   (o_im_consumed_lz77d),
    .o_im_consumed_xpd     (o_im_consumed_xpd),
    .o_ctl                 (o_ctl),
    .o_soft_rst            (o_soft_rst),
    .o_int_req             (int_req)
  );

  event_interrupt #(
    .N_INT_BITS (`INT_BITS)
  ) u_int (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_int_src     (i_int_src),
    .i_int_req     (int_req),
    .o_int_rd_data (int_rd_data),
    .o_int         (o_int)
  );

endmodule

// File: tb/tb_clkgen.sv
// Testbench clock and active-low reset generator.
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 4
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;  // released away from the sampling edge.
  end

endmodule

// File: tb/tb_cddip_support.sv
// Testbench with random stimulus, a cycle model of the register block, checks and a watchdog.
`timescale 1ns/1ps
`include "cddip_support_params.svh"

module tb_cddip_support;

  localparam logic [`RBUS_ADDR_BITS-1:0] WIN_START = 16'h0400;
  localparam logic [`RBUS_ADDR_BITS-1:0] WIN_END   = 16'h04ff;
  localparam int N_PASS    = 100;
  localparam int N_CTL     = 40;
  localparam int N_BANK    = 20;
  localparam int N_INT     = 60;
  localparam int N_TXN     = 11 + N_PASS + N_CTL + 2 * N_BANK + N_INT;
  localparam int RSP_LIMIT = 8;

  logic                          clk;
  logic                          rst_n;
  integer                        seed;
  logic                          src_en;
  logic [31:0]                   k;
  logic [31:0]                   rdata;
  logic [7:0]                    off;
  cddip_support_pkg::rbus_ring_t ring_in;
  cddip_support_pkg::rbus_ring_t ring_out;
  cddip_support_pkg::im_bank_t   avail_htf_bl;
  cddip_support_pkg::im_bank_t   avail_lz77d;
  cddip_support_pkg::im_bank_t   avail_xpd;
  cddip_support_pkg::im_bank_t   cons_htf_bl;
  cddip_support_pkg::im_bank_t   cons_lz77d;
  cddip_support_pkg::im_bank_t   cons_xpd;
  cddip_support_pkg::int_src_t   int_src;
  cddip_support_pkg::ctl_t       ctl_out;
  logic                          int_out;
  logic                          soft_rst_out;

  logic [`CTL_BITS-1:0]          m_ctl;
  logic                          m_soft_rst;
  logic [`INT_BITS-1:0]          m_status;
  logic [`INT_BITS-1:0]          m_mask;
  logic                          m_int;
  logic [5:0]                    m_avail;
  logic [5:0]                    m_consumed;
  logic                          p_wr;
  logic [7:0]                    p_off;
  logic [31:0]                   p_data;
  logic                          in_win;
  logic [`RBUS_ADDR_BITS-1:0]    in_off;

  tb_clkgen u_clkgen (.o_clk(clk), .o_rst_n(rst_n));

  cddip_support_top u_dut (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .i_cfg_start_addr      (WIN_START),
    .i_cfg_end_addr        (WIN_END),
    .i_rbus_ring           (ring_in),
    .o_rbus_ring           (ring_out),
    .i_im_available_htf_bl (avail_htf_bl),
    .i_im_available_lz77d  (avail_lz77d),
    .i_im_available_xpd    (avail_xpd),
    .o_im_consumed_htf_bl  (cons_htf_bl),
    .o_im_consumed_lz77d   (cons_lz77d),
    .o_im_consumed_xpd     (cons_xpd),
    .i_int_src             (int_src),
    .o_int                 (int_out),
    .o_ctl                 (ctl_out),
    .o_soft_rst            (soft_rst_out)
  );

  assign in_win = (ring_in.addr >= WIN_START) && (ring_in.addr <= WIN_END);
  assign in_off = ring_in.addr - WIN_START;

  // a window write lands in the registers one edge after the ring samples it.
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_ctl      <= '0;
      m_soft_rst <= 1'b0;
      m_status   <= '0;
      m_mask     <= '1;
      m_int      <= 1'b0;
      m_avail    <= '0;
      m_consumed <= '0;
      p_wr       <= 1'b0;
      p_off      <= '0;
      p_data     <= '0;
    end else begin
      p_wr       <= ring_in.wr_strb & in_win;
      p_off      <= in_off[7:0];
      p_data     <= ring_in.wr_data;
      m_avail    <= {avail_xpd, avail_lz77d, avail_htf_bl};
      m_consumed <= (p_wr && p_off == `REG_OFF_IM_CONSUMED) ? p_data[5:0] : 6'd0;
      if (p_wr && p_off == `REG_OFF_SOFT_RST) m_soft_rst <= p_data[0];
      if (p_wr && p_off == `REG_OFF_CTL) m_ctl <= p_data[`CTL_BITS-1:0];
      if (p_wr && p_off == `REG_OFF_INT_MASK) m_mask <= p_data[`INT_BITS-1:0];
      m_status <= (m_status & ~((p_wr && p_off == `REG_OFF_INT_STATUS) ?
                  p_data[`INT_BITS-1:0] : '0)) | int_src;  // the strobe wins.
      m_int    <= |(m_status & ~m_mask);
    end
  end

  always @(negedge clk) begin
    if (rst_n) begin
      assert (int_out == m_int)
        else report_mismatch($sformatf("o_int is %0b, model %0b", int_out, m_int));
      assert ({cons_xpd, cons_lz77d, cons_htf_bl} == m_consumed)
        else report_mismatch($sformatf("consumed pulses %b, model %b",
                             {cons_xpd, cons_lz77d, cons_htf_bl}, m_consumed));
      assert (ctl_out == m_ctl && soft_rst_out == m_soft_rst)
        else report_mismatch("o_ctl or o_soft_rst differs from the model");
    end
  end

  initial begin
    repeat (N_TXN * 6 + 200) @(posedge clk);
    $display("ERROR: watchdog expired before the tests finished");
    $display("FAIL: see errors above");
    $fatal(1, "watchdog timeout");
  end

  task automatic report_mismatch(input string msg);
    $display("FAIL @%0d ns: %s", $time, msg);
    $display("FAIL: see errors above");
    $fatal(1, "stopped at the first error");
  endtask

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic logic known_offset(input logic [7:0] o);
    return (o <= `REG_OFF_INT_MASK) && (o[1:0] == 2'b00);
  endfunction

  function automatic logic [31:0] expected_read(input logic [7:0] o);
    case (o)
      `REG_OFF_BLKID_REVID:  return {`CDDIP_BLKID, `CDDIP_REVID};
      `REG_OFF_SOFT_RST:     return {31'd0, m_soft_rst};
      `REG_OFF_CTL:          return {24'd0, m_ctl};
      `REG_OFF_IM_AVAILABLE: return {26'd0, m_avail};
      `REG_OFF_INT_STATUS:   return {18'd0, m_status};
      `REG_OFF_INT_MASK:     return {18'd0, m_mask};
      default:               return 32'd0;
    endcase
  endfunction

  // one clock; sparse source strobes are drawn while they are enabled.
  task automatic step();
    logic [31:0] a;
    logic [31:0] b;
    @(negedge clk);
    a = rand32();
    b = rand32();
    int_src = src_en ? cddip_support_pkg::int_src_t'(a[13:0] & b[13:0] & a[27:14]) : '0;
  endtask

  task automatic pass_access();
    cddip_support_pkg::rbus_ring_t req;
    logic [31:0] r;
    r = rand32();
    req.addr = r[31:16];
    if (req.addr >= WIN_START && req.addr <= WIN_END) req.addr = req.addr ^ 16'h8000;
    req.wr_strb = r[0] & ~r[1];
    req.rd_strb = r[1] & ~r[0];
    req.ack     = r[2];
    req.err_ack = r[3] & ~r[2];
    req.wr_data = rand32();
    req.rd_data = rand32();
    ring_in = req;
    step();
    assert (ring_out == req)
      else report_mismatch($sformatf("ring output %h, expected %h", ring_out, req));
  endtask

  task automatic reg_access(input logic is_wr, input logic [7:0] o, input logic [31:0] wdata,
                            output logic [31:0] rd);
    cddip_support_pkg::rbus_ring_t req;
    logic [31:0] exp_data;
    int edges;
    req         = '0;
    req.addr    = WIN_START + {8'h00, o};
    req.wr_strb = is_wr;
    req.rd_strb = ~is_wr;
    req.wr_data = wdata;
    ring_in     = req;
    exp_data    = '0;
    edges       = 0;
    do begin
      step();
      edges++;
      ring_in = '0;
      if (edges == 1) exp_data = expected_read(o);  // register state seen by the read.
      assert (!ring_out.wr_strb && !ring_out.rd_strb)
        else report_mismatch("a claimed strobe was forwarded on the ring");
    end while (!(ring_out.ack || ring_out.err_ack) && edges < RSP_LIMIT);
    assert (edges == 3)
      else report_mismatch($sformatf("offset %h answered after %0d edges", o, edges));
    assert (ring_out.ack == known_offset(o) && ring_out.err_ack == !known_offset(o))
      else report_mismatch($sformatf("offset %h got ack %0b err_ack %0b", o,
                           ring_out.ack, ring_out.err_ack));
    if (!is_wr && known_offset(o)) begin
      assert (ring_out.rd_data == exp_data)
        else report_mismatch($sformatf("read %h gave %h, expected %h", o,
                             ring_out.rd_data, exp_data));
    end
    rd = ring_out.rd_data;
  endtask

  initial begin
    seed         = 32'h5687_89cf;
    src_en       = 1'b0;
    ring_in      = '0;
    avail_htf_bl = '0;
    avail_lz77d  = '0;
    avail_xpd    = '0;
    int_src      = '0;
    @(posedge rst_n);

    off = 8'h00;
    repeat (7) begin
      reg_access(1'b0, off, 32'd0, rdata);
      off = off + 8'h04;
    end
    reg_access(1'b0, `REG_OFF_BLKID_REVID, 32'd0, rdata);
    assert (rdata == {`CDDIP_BLKID, `CDDIP_REVID})
      else report_mismatch($sformatf("block ID and revision read %h", rdata));
    reg_access(1'b0, `REG_OFF_INT_MASK, 32'd0, rdata);
    assert (rdata == {18'd0, {`INT_BITS{1'b1}}})
      else report_mismatch($sformatf("mask after reset read %h", rdata));

    repeat (N_PASS) pass_access();
    ring_in = '0;

    repeat (N_CTL) begin
      k = rand32();
      case (k[2:0])
        3'd0, 3'd1: reg_access(1'b1, `REG_OFF_CTL, rand32(), rdata);
        3'd2:       reg_access(1'b1, `REG_OFF_SOFT_RST, rand32(), rdata);
        3'd3:       reg_access(1'b0, `REG_OFF_CTL, 32'd0, rdata);
        3'd4:       reg_access(1'b0, `REG_OFF_SOFT_RST, 32'd0, rdata);
        default: begin
          off = k[15:8];
          if (known_offset(off)) off = off | 8'h80;  // no register lives above 0x18.
          reg_access(k[3], off, rand32(), rdata);
        end
      endcase
    end

    repeat (N_BANK) begin
      k = rand32();
      avail_htf_bl = k[1:0];
      avail_lz77d  = k[3:2];
      avail_xpd    = k[5:4];
      step();
      step();
      reg_access(1'b0, `REG_OFF_IM_AVAILABLE, 32'd0, rdata);
      assert (rdata == {26'd0, k[5:0]})
        else report_mismatch($sformatf("IM_AVAILABLE read %h for inputs %b", rdata, k[5:0]));
      reg_access(1'b1, `REG_OFF_IM_CONSUMED, rand32(), rdata);
    end

    src_en = 1'b1;
    repeat (N_INT) begin
      k = rand32();
      case (k[1:0])
        2'd0:    reg_access(1'b1, `REG_OFF_INT_MASK, rand32(), rdata);
        2'd1:    reg_access(1'b1, `REG_OFF_INT_STATUS, rand32(), rdata);
        2'd2:    reg_access(1'b0, `REG_OFF_INT_STATUS, 32'd0, rdata);
        default: reg_access(1'b0, `REG_OFF_INT_MASK, 32'd0, rdata);
      endcase
      step();
    end
    src_en = 1'b0;
    step();
    reg_access(1'b1, `REG_OFF_INT_STATUS, 32'hffff_ffff, rdata);
    reg_access(1'b0, `REG_OFF_INT_STATUS, 32'd0, rdata);
    assert (rdata == 32'd0)
      else report_mismatch($sformatf("status after full clear read %h", rdata));

    repeat (4) step();
    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+logic
logic/cddip_support_pkg.sv
logic/rbus_ring_node.sv
logic/support_regs.sv
logic/event_interrupt.sv
logic/cddip_support_top.sv
tb/tb_clkgen.sv
tb/tb_cddip_support.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_cddip_support
FILELIST  = vlog.f
OBJDIR    = obj_dir
PASS_MSG  = PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the output.
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
